// ==== hw/peakPkg.sv ====
package peakPkg;

   localparam int sampleW  = 16;         // bits per correlation value
   localparam int lanes    = 16;         // hypotheses per beat
   localparam int maxBeats = 4;          // beats in a multiH search
   localparam int indexW   = 6;          // covers 0 to 63

   typedef logic signed [sampleW-1:0] sample_t;
   typedef sample_t [lanes-1:0]       beat_t;     // lane 0 in the low bits
   typedef logic [indexW-1:0]         index_t;

   typedef enum logic {
      singleH,                           // one beat, indices 0 to 15
      multiH                             // four beats, indices 0 to 63
   } searchMode_t;

   typedef enum logic {
      idle,
      collect                            // search open, counting beats
   } decState_t;

   // true only when y is strictly larger than x, so a tie keeps x
   function automatic logic isGreater(input sample_t x, input sample_t y);
      return y > x;                      // both signed
   endfunction

endpackage

// ==== hw/searchIf.sv ====
`timescale 1ns/100ps

interface beatIf;
   import peakPkg::*;

   logic   valid;                        // beat accepted on this edge
   logic   first;                        // beat 0 of the search
   logic   last;                         // closing beat for the mode
   index_t beatBase;                     // beat number times lanes

   modport source (
      output valid, first, last, beatBase
   );

   modport sink (
      input valid, first, last, beatBase
   );

endinterface

interface candIf;
   import peakPkg::*;

   logic    valid;
   logic    first;
   logic    last;
   sample_t value;                       // best value of the beat
   index_t  index;                       // its hypothesis index

   modport source (
      output valid, first, last, value, index
   );

   modport sink (
      input valid, first, last, value, index
   );

endinterface

// ==== hw/searchDecode.sv ====
`timescale 1ns/100ps

module searchDecode (
   input  logic  clk,
   input  logic  reset,
   input  logic  start,
   input  logic  multiH,
   input  logic  sampleValid,
   output logic  busy,
   beatIf.source beat
);
   import peakPkg::*;

   decState_t   state;
   searchMode_t mode;                    // latched at the accepted start
   logic [1:0]  beatCnt;                 // beat number inside the search
   logic        lastBeat;

   // final beat depends on the latched mode
   assign lastBeat = (mode == singleH) || (beatCnt == 2'(maxBeats - 1));

   assign busy = (state == collect);

   // beat tags are combinational, valid in the cycle before the edge
   assign beat.valid    = busy && sampleValid;
   assign beat.first    = (beatCnt == 2'd0);
   assign beat.last     = lastBeat;
   assign beat.beatBase = index_t'(beatCnt) * index_t'(lanes);

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= idle;
         mode    <= singleH;
         beatCnt <= 2'd0;
      end else begin
         case (state)
            idle: begin
               if (start) begin             // start only counts while idle
                  state   <= collect;
                  mode    <= searchMode_t'(multiH);
                  beatCnt <= 2'd0;
               end
            end
            collect: begin
               if (sampleValid) begin
                  if (lastBeat) begin
                     state <= idle;         // busy drops with the last beat
                  end
                  beatCnt <= beatCnt + 2'd1;
               end
            end
            default: begin
               state <= idle;
            end
         endcase
      end
   end

endmodule

// ==== hw/compSel.sv ====
`timescale 1ns/100ps

module compSel #(
   parameter int indexOffset = 0
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             ce,
   input  peakPkg::sample_t a,
   input  peakPkg::sample_t b,
   input  peakPkg::sample_t c,
   input  peakPkg::sample_t d,
   output peakPkg::index_t  index,
   output peakPkg::sample_t maxVal
);
   import peakPkg::*;

   logic       selAB;                    // b beats a
   logic       selCD;                    // d beats c
   logic       selTop;                   // c/d pair beats a/b pair
   sample_t    winAB;
   sample_t    winCD;
   sample_t    tempVal;
   logic [1:0] idxAB;
   logic [1:0] idxCD;
   logic [1:0] tempIdx;                  // position of the winner

   // first round, two pairs
   assign selAB = isGreater(a, b);
   assign winAB = selAB ? b : a;
   assign idxAB = selAB ? 2'd1 : 2'd0;

   assign selCD = isGreater(c, d);
   assign winCD = selCD ? d : c;
   assign idxCD = selCD ? 2'd3 : 2'd2;

   // final round, ties stay with the a/b side
   assign selTop  = isGreater(winAB, winCD);
   assign tempVal = selTop ? winCD : winAB;
   assign tempIdx = selTop ? idxCD : idxAB;

   always_ff @(posedge clk) begin
      if (reset) begin
         index  <= '0;
         maxVal <= '0;
      end else if (ce) begin
         index  <= index_t'(tempIdx) + index_t'(indexOffset);
         maxVal <= tempVal;
      end
   end

endmodule

// ==== hw/peakTreeExecute.sv ====
`timescale 1ns/100ps

module peakTreeExecute (
   input  logic           clk,
   input  logic           reset,
   input  peakPkg::beat_t samples,
   beatIf.sink            beat,
   candIf.source          cand
);
   import peakPkg::*;

   sample_t l1Val  [0:3];                // group winners, loaded at E
   index_t  l1Idx  [0:3];                // lane index of each group winner
   index_t  l1IdxD [0:3];                // same, held for the second level
   index_t  grpIdx;                      // winning group from the top stage
   logic    valid1;
   logic    valid2;
   logic    first1;
   logic    first2;
   logic    last1;
   logic    last2;
   index_t  base1;
   index_t  base2;

   // first level, four lanes per selector
   for (genvar g = 0; g < 4; g++) begin : gL1
      compSel #(.indexOffset(4 * g)) compSel_i (
         .clk    (clk),
         .reset  (reset),
         .ce     (beat.valid),
         .a      (samples[4*g]),
         .b      (samples[4*g+1]),
         .c      (samples[4*g+2]),
         .d      (samples[4*g+3]),
         .index  (l1Idx[g]),
         .maxVal (l1Val[g])
      );
   end

   // second level picks the group, loads at E+1
   compSel #(.indexOffset(0)) compSelTop_i (
      .clk    (clk),
      .reset  (reset),
      .ce     (valid1),
      .a      (l1Val[0]),
      .b      (l1Val[1]),
      .c      (l1Val[2]),
      .d      (l1Val[3]),
      .index  (grpIdx),
      .maxVal (cand.value)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         valid1 <= 1'b0;
         valid2 <= 1'b0;
      end else begin
         valid1 <= beat.valid;
         valid2 <= valid1;
      end
   end

   // tags follow the data through both levels
   always_ff @(posedge clk) begin
      if (beat.valid) begin
         first1 <= beat.first;
         last1  <= beat.last;
         base1  <= beat.beatBase;
      end
      if (valid1) begin
         first2 <= first1;
         last2  <= last1;
         base2  <= base1;
         l1IdxD <= l1Idx;                // a new beat may reload level one now
      end
   end

   assign cand.valid = valid2;
   assign cand.first = first2;
   assign cand.last  = last2;
   assign cand.index = base2 + l1IdxD[grpIdx[1:0]];

endmodule

// ==== hw/peakResult.sv ====
`timescale 1ns/100ps

module peakResult (
   input  logic             clk,
   input  logic             reset,
   candIf.sink              cand,
   output logic             peakValid,
   output peakPkg::index_t  peakIndex,
   output peakPkg::sample_t peakVal
);
   import peakPkg::*;

   sample_t accVal;                      // running maximum of the search
   index_t  accIdx;
   logic    takeNew;
   sample_t nextVal;
   index_t  nextIdx;

   // earlier beats win ties, so a later equal value is dropped
   assign takeNew = cand.first || isGreater(accVal, cand.value);
   assign nextVal = takeNew ? cand.value : accVal;
   assign nextIdx = takeNew ? cand.index : accIdx;

   always_ff @(posedge clk) begin
      if (cand.valid) begin
         accVal <= nextVal;
         accIdx <= nextIdx;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         peakValid <= 1'b0;
         peakIndex <= '0;
         peakVal   <= '0;
      end else begin
         peakValid <= cand.valid && cand.last;   // one-cycle strobe
         if (cand.valid && cand.last) begin
            peakIndex <= nextIdx;               // held until the next peak
            peakVal   <= nextVal;
         end
      end
   end

endmodule

// ==== hw/peakSearch.sv ====
`timescale 1ns/100ps

module peakSearch (
   input  logic             clk,
   input  logic             reset,
   input  logic             start,
   input  logic             multiH,
   input  logic             sampleValid,
   input  peakPkg::beat_t   samples,
   output logic             busy,
   output logic             peakValid,
   output peakPkg::index_t  peakIndex,
   output peakPkg::sample_t peakVal
);

   beatIf beatBus ();                    // decode to execute
   candIf candBus ();                    // execute to result

   searchDecode searchDecode_i (
      .clk         (clk),
      .reset       (reset),
      .start       (start),
      .multiH      (multiH),
      .sampleValid (sampleValid),
      .busy        (busy),
      .beat        (beatBus.source)
   );

   peakTreeExecute peakTreeExecute_i (
      .clk     (clk),
      .reset   (reset),
      .samples (samples),
      .beat    (beatBus.sink),
      .cand    (candBus.source)
   );

   peakResult peakResult_i (
      .clk       (clk),
      .reset     (reset),
      .cand      (candBus.sink),
      .peakValid (peakValid),
      .peakIndex (peakIndex),
      .peakVal   (peakVal)
   );

endmodule

// ==== verif/peakSearch_assert.sv ====
`timescale 1ns/100ps

module peakSearch_assert (
   input logic clk,
   input logic reset,
   input logic sampleValid,
   input logic busy,
   input logic peakValid
);

   peakOneCycle: assert property (@(posedge clk) disable iff (reset)
      peakValid |=> !peakValid)
      else $error("peakValid high on two consecutive cycles");

   // beat accepted three edges before the peak is seen
   peakAfterBeat: assert property (@(posedge clk) disable iff (reset)
      peakValid |-> $past(busy && sampleValid, 3))
      else $error("peakValid without an accepted beat three cycles earlier");

   resetClears: assert property (@(posedge clk)
      reset |=> (!busy && !peakValid))
      else $error("busy or peakValid high in the cycle after reset");

endmodule

bind peakSearch peakSearch_assert peakSearch_assert_i (.*);

// ==== verif/peakSearchTb.sv ====
`timescale 1ns/100ps

module peakSearchTb;
   import peakPkg::*;

   typedef struct packed {
      index_t  idx;
      sample_t val;
      int      cycle;                    // cycle in which the last beat was driven
      int      lim;                      // hypotheses in the search
   } exp_t;

   localparam int nSingle    = 16;
   localparam int nMulti     = 16;
   localparam int nBack      = 8;
   localparam int nNoise     = 4;
   localparam int maxGap     = 3;
   localparam int totalBeats = nSingle + maxBeats * (nMulti + nBack + nNoise + 5);
   localparam int watchLimit = totalBeats * (maxGap + 3) + 200;

   logic        clk;
   logic        reset;
   logic        start;
   logic        multiH;
   logic        sampleValid;
   logic        busy;
   logic        peakValid;
   beat_t       samples;
   index_t      peakIndex;
   sample_t     peakVal;
   logic [31:0] lfsr;
   sample_t     hyp [0:63];              // hypotheses of the search being driven
   exp_t        expQ [$];
   int          cycle = 0;
   int          checks;
   int          errors;
   int          errBefore;

   peakSearch peakSearch_i (.*);

   always #20 clk = ~clk;

   always @(posedge clk) cycle <= cycle + 1;

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // strict greater only, so the lowest index keeps a tie
   function automatic exp_t refPeak(input int n);
      exp_t r;
      r = '{idx: '0, val: hyp[0], cycle: 0, lim: n};
      for (int i = 1; i < n; i++) begin
         if (hyp[i] > r.val) begin
            r.idx = index_t'(i);
            r.val = hyp[i];
         end
      end
      return r;
   endfunction

   function automatic beat_t packBeat(input int b);
      beat_t r;
      for (int l = 0; l < lanes; l++) begin
         r[l] = hyp[b * lanes + l];
      end
      return r;
   endfunction

   task automatic fillRandom;
      for (int i = 0; i < 64; i++) begin
         hyp[i] = sample_t'(randBits(sampleW));
      end
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %s: got %h expected %h", name, got, exp);
      end
   endtask

   // noise adds an idle beat before start and a repeated start while busy
   task automatic driveSearch(input logic m, input int gapMax, input logic noise);
      int   nb;
      int   gap;
      int   lastDrive;
      exp_t e;
      nb = m ? maxBeats : 1;
      if (noise) begin
         samples     = beat_t'({8{randBits(32)}});
         sampleValid = 1'b1;
         @(posedge clk);
         #2;
         sampleValid = 1'b0;
      end
      start  = 1'b1;
      multiH = m;
      @(posedge clk);
      #2;
      start     = noise;
      multiH    = ~m;                    // mode is already latched
      lastDrive = cycle;
      for (int b = 0; b < nb; b++) begin
         gap = int'(randBits(2)) % (gapMax + 1);
         repeat (gap) begin
            @(posedge clk);
            #2;
         end
         samples     = packBeat(b);
         sampleValid = 1'b1;
         lastDrive   = cycle;
         @(posedge clk);
         #2;
         sampleValid = 1'b0;
         start       = 1'b0;
      end
      e       = refPeak(nb * lanes);
      e.cycle = lastDrive;
      expQ.push_back(e);
   endtask

   task automatic drain;
      for (int w = 0; w < 8 && expQ.size() != 0; w++) begin
         @(posedge clk);
         #2;
      end
      if (expQ.size() != 0) begin
         errors++;
         $display("no peakValid for %0d pending searches", expQ.size());
      end
   endtask

   task automatic reportTest(input string name);
      $display("test %s finished with %0d errors", name, errors - errBefore);
      errBefore = errors;
   endtask

   always @(negedge clk) begin : comparePeaks
      exp_t e;
      if (!reset && peakValid) begin
         if (expQ.size() == 0) begin
            errors++;
            $display("peakValid without a pending search in cycle %0d", cycle);
         end else begin
            e = expQ.pop_front();
            check("peakIndex", 32'(peakIndex), 32'(e.idx));
            check("peakVal", 32'(peakVal), 32'(e.val));
            if (e.lim < maxBeats * lanes) begin   // a multiH index spans the whole width
               check("peakIndexRange", 32'(peakIndex < e.lim), 32'd1);
            end
            check("peakLatency", 32'(cycle - e.cycle), 32'd3);   // sampleValid to peakValid
         end
      end
   end

   initial begin : watchdog
      repeat (watchLimit) @(posedge clk);
      $display("watchdog expired after %0d cycles", watchLimit);
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      {clk, start, multiH, sampleValid} = '0;
      reset     = 1'b1;
      samples   = '0;
      lfsr      = 32'h541fe7a7;
      checks    = 0;
      errors    = 0;
      errBefore = 0;
      repeat (10) @(posedge clk);
      #2;
      reset = 1'b0;
      repeat (nSingle) begin
         fillRandom();
         driveSearch(1'b0, maxGap, 1'b0);
      end
      drain();
      reportTest("randomSingleH");
      repeat (nMulti) begin
         fillRandom();
         driveSearch(1'b1, maxGap, 1'b0);
      end
      drain();
      reportTest("randomMultiH");
      for (int i = 0; i < 64; i++) begin
         hyp[i] = sample_t'(-5);
      end
      driveSearch(1'b1, 0, 1'b0);
      for (int i = 0; i < 64; i++) begin
         hyp[i] = (i == 63) ? sample_t'(100) : sample_t'(-1);
      end
      driveSearch(1'b1, 0, 1'b0);
      for (int i = 0; i < 64; i++) begin
         hyp[i] = (i == 9) ? sample_t'(1) : sample_t'(16'h8000);   // most negative value
      end
      driveSearch(1'b0, 0, 1'b0);
      drain();
      reportTest("directed");
      repeat (nBack) begin
         fillRandom();
         driveSearch(1'(randBits(1)), 0, 1'b0);
      end
      drain();
      reportTest("backToBack");
      repeat (nNoise) begin
         fillRandom();
         driveSearch(1'(randBits(1)), maxGap, 1'b1);
      end
      drain();
      reportTest("ignoredStrobes");
      fillRandom();
      start  = 1'b1;
      multiH = 1'b0;
      @(posedge clk);
      #2;
      start       = 1'b0;
      samples     = packBeat(0);
      sampleValid = 1'b1;
      @(posedge clk);                    // singleH beat taken, its peak loads two edges later
      #2;
      expQ.push_back(refPeak(lanes));
      sampleValid = 1'b0;
      start       = 1'b1;                // next search opens with that peak in flight
      multiH      = 1'b1;
      @(posedge clk);
      #2;
      start       = 1'b0;
      samples     = packBeat(1);
      sampleValid = 1'b1;
      reset       = 1'b1;                // hits with busy high and the peak about to load
      @(posedge clk);
      #2;
      check("busy", 32'(busy), 32'd0);
      check("peakValid", 32'(peakValid), 32'd0);
      sampleValid = 1'b0;
      repeat (2) begin
         @(posedge clk);
         #2;
      end
      reset = 1'b0;
      expQ.delete();
      fillRandom();
      driveSearch(1'b1, maxGap, 1'b0);
      drain();
      reportTest("midSearchReset");
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// ==== files.f ====
hw/peakPkg.sv
hw/searchIf.sv
hw/searchDecode.sv
hw/compSel.sv
hw/peakTreeExecute.sv
hw/peakResult.sv
hw/peakSearch.sv
verif/peakSearch_assert.sv
verif/peakSearchTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the peak-search testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module peakSearchTb -f files.f
./obj_dir/VpeakSearchTb | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
   echo "run passed"
else
   echo "run failed, see sim.log"
   exit 1
fi
